// File: logic/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

  // ------------------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------------------
  localparam int DATA_WIDTH        = 8;
  localparam int DEPTH             = 8;
  localparam int THRESHOLD         = 6;
  localparam int RAM_WORDS         = DEPTH - 1;  // The head entry lives in a flip-flop.
  localparam int MATCH_COUNT_WIDTH = 2;          // All ones marks a saturated entry.

  // ------------------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------------------
  typedef logic [DATA_WIDTH-1:0]          data_t;
  typedef logic [$clog2(DEPTH+1)-1:0]     count_t;    // Entry count from 0 to DEPTH.
  typedef logic [$clog2(RAM_WORDS)-1:0]   ram_ptr_t;
  typedef logic [$clog2(DEPTH)-1:0]       ptr_t;      // Entry index for repeat counters.

endpackage

`default_nettype wire

// File: logic/fifo_controller.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_controller (
  input  var logic               i_clk,
  input  var logic               i_rst_n,
  input  var logic               i_clear,
  input  var logic               i_push,
  input  var logic               i_pop,
  input  var fifo_pkg::data_t    i_data,
  output logic                   o_empty,
  output logic                   o_almost_full,
  output logic                   o_full,
  output fifo_pkg::count_t       o_word_count,
  output fifo_pkg::ram_ptr_t     o_write_pointer,
  output fifo_pkg::ram_ptr_t     o_read_pointer,
  output logic                   o_write_to_ff,
  output logic                   o_write_to_ram,
  output logic                   o_read_from_ram
);

  typedef logic [fifo_pkg::MATCH_COUNT_WIDTH-1:0] match_count_t;

  logic                        push_new;     // Push that opens a new entry.
  logic                        push_match;   // Push that joins the newest entry.
  logic                        pop_word;
  logic                        pop_entry;    // Pop that retires the head entry.
  logic                        update_state;
  fifo_pkg::count_t            word_count;
  fifo_pkg::count_t            count_next;
  logic                        empty_q;
  logic                        almost_full_q;
  logic                        full_q;
  logic                        write_to_ff;
  logic                        write_to_ram;
  logic                        read_from_ram;
  logic                        ram_empty_next;
  fifo_pkg::ram_ptr_t          ram_wr_ptr;
  fifo_pkg::ram_ptr_t          ram_rd_ptr;
  fifo_pkg::ptr_t              entry_wr_ptr;
  fifo_pkg::ptr_t              entry_rd_ptr;
  fifo_pkg::ptr_t              entry_last_ptr;
  fifo_pkg::data_t             last_data;
  logic                        match_data;
  logic                        last_word;
  logic [fifo_pkg::DEPTH-1:0]  count_up;
  logic [fifo_pkg::DEPTH-1:0]  count_down;
  match_count_t                match_count [fifo_pkg::DEPTH];

  function automatic fifo_pkg::ram_ptr_t next_ram_ptr(fifo_pkg::ram_ptr_t ptr);
    if (ptr == fifo_pkg::ram_ptr_t'(fifo_pkg::RAM_WORDS - 1)) begin
      return '0;
    end
    return ptr + fifo_pkg::ram_ptr_t'(1);
  endfunction

  always_comb begin
    push_new     = i_push && !i_clear && !full_q && !match_data;
    push_match   = i_push && match_data;
    pop_word     = i_pop && !i_clear && !empty_q;
    pop_entry    = pop_word && last_word;
    update_state = push_new || pop_entry || i_clear;
  end

  // --------------------------------------------------------------------------
  // Entry counter and flags
  // --------------------------------------------------------------------------
  always_comb begin
    if (i_clear) begin
      count_next = '0;
    end else if (push_new && !pop_entry) begin
      count_next = word_count + fifo_pkg::count_t'(1);
    end else if (pop_entry && !push_new) begin
      count_next = word_count - fifo_pkg::count_t'(1);
    end else begin
      count_next = word_count;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      word_count    <= '0;
      empty_q       <= 1'b1;
      almost_full_q <= 1'b0;
      full_q        <= 1'b0;
    end else if (update_state) begin
      word_count    <= count_next;
      empty_q       <= count_next == '0;
      almost_full_q <= count_next >= fifo_pkg::count_t'(fifo_pkg::THRESHOLD);
      full_q        <= count_next >= fifo_pkg::count_t'(fifo_pkg::DEPTH);
    end
  end

  // --------------------------------------------------------------------------
  // Write and read steering
  // --------------------------------------------------------------------------
  always_comb begin
    if (empty_q || (pop_entry && (word_count == fifo_pkg::count_t'(1)))) begin
      write_to_ff  = push_new;      // Head is free after this edge.
      write_to_ram = 1'b0;
    end else begin
      write_to_ff  = 1'b0;
      write_to_ram = push_new;
    end
    read_from_ram  = pop_entry && (word_count >= fifo_pkg::count_t'(2));
    ram_empty_next = read_from_ram && !write_to_ram &&
                     (word_count == fifo_pkg::count_t'(2));
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      ram_wr_ptr <= '0;
      ram_rd_ptr <= '0;
    end else if (i_clear) begin
      ram_wr_ptr <= '0;
      ram_rd_ptr <= '0;
    end else if (ram_empty_next) begin
      ram_wr_ptr <= ram_rd_ptr;     // RAM drained so both pointers meet.
    end else begin
      if (write_to_ram) begin
        ram_wr_ptr <= next_ram_ptr(ram_wr_ptr);
      end
      if (read_from_ram) begin
        ram_rd_ptr <= next_ram_ptr(ram_rd_ptr);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Repeat counters
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      entry_wr_ptr <= '0;
      entry_rd_ptr <= '0;
    end else if (i_clear) begin
      entry_wr_ptr <= '0;
      entry_rd_ptr <= '0;
    end else begin
      if (push_new) begin
        entry_wr_ptr <= entry_wr_ptr + fifo_pkg::ptr_t'(1);
      end
      if (pop_entry) begin
        entry_rd_ptr <= entry_rd_ptr + fifo_pkg::ptr_t'(1);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_new) begin
      last_data <= i_data;
    end
  end

  always_comb begin
    entry_last_ptr = entry_wr_ptr - fifo_pkg::ptr_t'(1);
    match_data     = !empty_q && (i_data == last_data) && (match_count[entry_last_ptr] != '1);
    for (int i = 0; i < fifo_pkg::DEPTH; i++) begin
      count_up[i]   = (push_new && (entry_wr_ptr == fifo_pkg::ptr_t'(i))) ||
                      (push_match && (entry_last_ptr == fifo_pkg::ptr_t'(i)));
      count_down[i] = pop_word && (entry_rd_ptr == fifo_pkg::ptr_t'(i));
    end
    last_word = (match_count[entry_rd_ptr] == match_count_t'(1)) && !count_up[entry_rd_ptr];
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < fifo_pkg::DEPTH; i++) begin
        match_count[i] <= '0;
      end
    end else if (i_clear) begin
      for (int i = 0; i < fifo_pkg::DEPTH; i++) begin
        match_count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < fifo_pkg::DEPTH; i++) begin
        if (count_up[i] && !count_down[i]) begin
          match_count[i] <= match_count[i] + match_count_t'(1);
        end else if (count_down[i] && !count_up[i]) begin
          match_count[i] <= match_count[i] - match_count_t'(1);
        end
      end
    end
  end

  always_comb begin
    o_empty         = empty_q;
    o_almost_full   = almost_full_q;
    o_full          = full_q && !match_data;   // A matching word still fits.
    o_word_count    = word_count;
    o_write_pointer = ram_wr_ptr;
    o_read_pointer  = ram_rd_ptr;
    o_write_to_ff   = write_to_ff;
    o_write_to_ram  = write_to_ram;
    o_read_from_ram = read_from_ram;
  end

endmodule

`default_nettype wire

// File: logic/fifo_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_ram (
  input  var logic                i_clk,
  input  var logic                i_write,
  input  var fifo_pkg::ram_ptr_t  i_write_pointer,
  input  var fifo_pkg::ram_ptr_t  i_read_pointer,
  input  var fifo_pkg::data_t     i_write_data,
  output fifo_pkg::data_t         o_read_data
);

  fifo_pkg::data_t mem [fifo_pkg::RAM_WORDS];

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_write) begin
      mem[i_write_pointer] <= i_write_data;
    end
  end

  // Read is combinational so the head can refill on the pop edge.
  always_comb begin
    o_read_data = mem[i_read_pointer];
  end

endmodule

`default_nettype wire

// File: logic/fifo_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_output_stage (
  input  var logic             i_clk,
  input  var logic             i_rst_n,
  input  var logic             i_load_push,
  input  var logic             i_load_ram,
  input  var fifo_pkg::data_t  i_push_data,
  input  var fifo_pkg::data_t  i_ram_data,
  output fifo_pkg::data_t      o_data
);

  fifo_pkg::data_t head;
  fifo_pkg::data_t head_next;
  logic            head_load;

  // --------------------------------------------------------------------------
  // Head select
  // --------------------------------------------------------------------------
  always_comb begin
    head_load = i_load_ram || i_load_push;
    if (i_load_ram) begin
      head_next = i_ram_data;    // Refill from RAM wins over a push.
    end else begin
      head_next = i_push_data;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      head <= '0;
    end else if (head_load) begin
      head <= head_next;
    end
  end

  always_comb begin
    o_data = head;
  end

endmodule

`default_nettype wire

// File: logic/fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_top (
  input  var logic             i_clk,
  input  var logic             i_rst_n,
  input  var logic             i_clear,
  input  var logic             i_push,
  input  var logic             i_pop,
  input  var fifo_pkg::data_t  i_data,
  output fifo_pkg::data_t      o_data,
  output logic                 o_empty,
  output logic                 o_almost_full,
  output logic                 o_full,
  output fifo_pkg::count_t     o_word_count
);

  fifo_pkg::ram_ptr_t  write_pointer;
  fifo_pkg::ram_ptr_t  read_pointer;
  logic                write_to_ff;
  logic                write_to_ram;
  logic                read_from_ram;
  fifo_pkg::data_t     ram_read_data;

  fifo_controller u_controller (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_clear          (i_clear),
    .i_push           (i_push),
    .i_pop            (i_pop),
    .i_data           (i_data),
    .o_empty          (o_empty),
    .o_almost_full    (o_almost_full),
    .o_full           (o_full),
    .o_word_count     (o_word_count),
    .o_write_pointer  (write_pointer),
    .o_read_pointer   (read_pointer),
    .o_write_to_ff    (write_to_ff),
    .o_write_to_ram   (write_to_ram),
    .o_read_from_ram  (read_from_ram)
  );

  fifo_ram u_ram (
    .i_clk            (i_clk),
    .i_write          (write_to_ram),
    .i_write_pointer  (write_pointer),
    .i_read_pointer   (read_pointer),
    .i_write_data     (i_data),
    .o_read_data      (ram_read_data)
  );

  fifo_output_stage u_output_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_load_push      (write_to_ff),
    .i_load_ram       (read_from_ram),
    .i_push_data      (i_data),
    .i_ram_data       (ram_read_data),
    .o_data           (o_data)
  );

endmodule

`default_nettype wire

// File: sim/tb_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_top;

  localparam int CLK_PERIOD  = 4;
  localparam int TEST_CYCLES = 8 + 4 + 20 + 40 + 240 + 30;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

  logic              i_clk = 1'b0;
  logic              i_rst_n;
  logic              i_clear;
  logic              i_push;
  logic              i_pop;
  fifo_pkg::data_t   i_data;
  fifo_pkg::data_t   o_data;
  logic              o_empty;
  logic              o_almost_full;
  logic              o_full;
  fifo_pkg::count_t  o_word_count;

  fifo_pkg::data_t   q_word [$];  // Reference entries with the head at index 0.
  int                q_rep [$];   // Words held by each reference entry.
  logic [31:0]       lfsr_state = 32'ha162193e;
  int                check_count = 0;
  int                error_count = 0;
  int                test_count = 0;

  fifo_top uut (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_clear        (i_clear),
    .i_push         (i_push),
    .i_pop          (i_pop),
    .i_data         (i_data),
    .o_data         (o_data),
    .o_empty        (o_empty),
    .o_almost_full  (o_almost_full),
    .o_full         (o_full),
    .o_word_count   (o_word_count)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ------------------------------------------------------------------------
  // Random bits and checking
  // ------------------------------------------------------------------------
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic check_value(input string what, input int got, input int exp);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("** Error %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    test_count++;
    $display("%s finished with %0d errors", name, error_count - start_errors);
  endtask

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  task automatic compare_outputs(input fifo_pkg::data_t data);
    int n;
    int match_ok;
    n = q_word.size();
    match_ok = 0;
    if (n > 0 && q_word[n-1] == data && q_rep[n-1] < 3) match_ok = 1;
    check_value("o_word_count", int'(o_word_count), n);
    check_value("o_empty", int'(o_empty), (n == 0) ? 1 : 0);
    check_value("o_almost_full", int'(o_almost_full), (n >= fifo_pkg::THRESHOLD) ? 1 : 0);
    check_value("o_full", int'(o_full), (n >= fifo_pkg::DEPTH && match_ok == 0) ? 1 : 0);
    if (n > 0) check_value("o_data", int'(o_data), int'(q_word[0]));
  endtask

  task automatic update_model(input logic push, input logic pop, input logic clr,
                              input fifo_pkg::data_t data);
    int n;
    n = q_word.size();
    if (clr) begin
      q_word.delete();
      q_rep.delete();
    end else begin
      if (push && n > 0 && q_word[n-1] == data && q_rep[n-1] < 3) begin
        q_rep[n-1] = q_rep[n-1] + 1;  // Repeated word joins the newest entry.
      end else if (push && n < fifo_pkg::DEPTH) begin
        q_word.push_back(data);
        q_rep.push_back(1);
      end
      if (pop && n > 0) begin
        q_rep[0] = q_rep[0] - 1;
        if (q_rep[0] == 0) begin
          void'(q_word.pop_front());
          void'(q_rep.pop_front());
        end
      end
    end
  endtask

  // Inputs driven here are taken at the next rising edge.
  task automatic drive_cycle(input logic push, input logic pop, input logic clr,
                             input fifo_pkg::data_t data);
    @(posedge i_clk);
    i_push  <= push;
    i_pop   <= pop;
    i_clear <= clr;
    i_data  <= data;
    @(negedge i_clk);
    compare_outputs(data);
    update_model(push, pop, clr, data);
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
  endtask

  // ------------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------------
  task automatic test_reset_state();
    int start;
    start = error_count;
    @(negedge i_clk);
    check_value("o_empty", int'(o_empty), 1);
    check_value("o_almost_full", int'(o_almost_full), 0);
    check_value("o_full", int'(o_full), 0);
    check_value("o_word_count", int'(o_word_count), 0);
    check_value("o_data", int'(o_data), 0);
    report_test("reset_state", start);
  endtask

  task automatic test_fill_drain();
    int start;
    start = error_count;
    for (int i = 0; i < 8; i++) begin
      drive_cycle(1'b1, 1'b0, 1'b0, fifo_pkg::data_t'(8'h10 + i));
      if (i == 5) check_value("o_almost_full at 5", int'(o_almost_full), 0);
      if (i == 6) check_value("o_almost_full at 6", int'(o_almost_full), 1);
    end
    drive_cycle(1'b1, 1'b0, 1'b0, 8'h77);  // Dropped because the FIFO is full.
    idle_cycle();
    check_value("o_full when full", int'(o_full), 1);
    check_value("o_word_count when full", int'(o_word_count), 8);
    for (int i = 0; i < 8; i++) begin
      drive_cycle(1'b0, 1'b1, 1'b0, 8'h00);
      check_value("popped word", int'(o_data), 'h10 + i);
    end
    idle_cycle();
    check_value("o_empty after drain", int'(o_empty), 1);
    report_test("fill_drain", start);
  endtask

  task automatic test_compression();
    int start;
    start = error_count;
    repeat (5) drive_cycle(1'b1, 1'b0, 1'b0, 8'hA5);
    idle_cycle();
    check_value("entries for five repeats", int'(o_word_count), 2);
    repeat (5) begin
      drive_cycle(1'b0, 1'b1, 1'b0, 8'h00);
      check_value("repeated word", int'(o_data), 'hA5);
    end
    idle_cycle();
    check_value("o_empty after repeats", int'(o_empty), 1);
    for (int i = 0; i < 8; i++) begin
      drive_cycle(1'b1, 1'b0, 1'b0, fifo_pkg::data_t'(8'hB0 + i));
    end
    drive_cycle(1'b1, 1'b0, 1'b0, 8'hB7);
    check_value("o_full with matching word", int'(o_full), 0);
    for (int i = 0; i < 9; i++) begin
      drive_cycle(1'b0, 1'b1, 1'b0, 8'h00);
      check_value("popped word", int'(o_data), (i < 8) ? 'hB0 + i : 'hB7);
    end
    idle_cycle();
    check_value("o_empty after full match", int'(o_empty), 1);
    report_test("compression", start);
  endtask

  task automatic test_random_traffic();
    int   start;
    logic push;
    logic pop;
    start = error_count;
    for (int k = 0; k < 200; k++) begin
      if (k < 100) begin
        push = lfsr_step() | lfsr_step();  // Mostly pushing so the FIFO fills.
        pop  = lfsr_step();
      end else begin
        push = lfsr_step();
        pop  = lfsr_step() | lfsr_step();
      end
      drive_cycle(push, pop, 1'b0, 8'h40 | rand_bits(2));
    end
    for (int k = 0; k < 30 && q_word.size() > 0; k++) begin
      drive_cycle(1'b0, 1'b1, 1'b0, 8'h00);
    end
    idle_cycle();
    report_test("random_traffic", start);
  endtask

  task automatic test_clear();
    int start;
    start = error_count;
    for (int i = 0; i < 3; i++) begin
      drive_cycle(1'b1, 1'b0, 1'b0, fifo_pkg::data_t'(8'h21 + i));
    end
    drive_cycle(1'b1, 1'b1, 1'b1, 8'h99);  // Clear wins over push and pop.
    idle_cycle();
    check_value("o_word_count after clear", int'(o_word_count), 0);
    drive_cycle(1'b1, 1'b0, 1'b0, 8'hC3);
    idle_cycle();
    check_value("first word after clear", int'(o_data), 'hC3);
    for (int i = 0; i < 7; i++) begin
      drive_cycle(1'b1, 1'b0, 1'b0, fifo_pkg::data_t'(8'h31 + i));
    end
    drive_cycle(1'b0, 1'b0, 1'b1, 8'h00);
    idle_cycle();
    check_value("o_empty after full clear", int'(o_empty), 1);
    drive_cycle(1'b1, 1'b0, 1'b0, 8'hD4);
    idle_cycle();
    check_value("first word after full clear", int'(o_data), 'hD4);
    drive_cycle(1'b0, 1'b1, 1'b0, 8'h00);
    idle_cycle();
    report_test("clear", start);
  endtask

  initial begin
    i_rst_n <= 1'b0;
    i_clear <= 1'b0;
    i_push  <= 1'b0;
    i_pop   <= 1'b0;
    i_data  <= '0;
    repeat (8) @(posedge i_clk);
    i_rst_n <= 1'b1;
    test_reset_state();
    test_fill_drain();
    test_compression();
    test_random_traffic();
    test_clear();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
logic/fifo_pkg.sv
logic/fifo_controller.sv
logic/fifo_ram.sv
logic/fifo_output_stage.sv
logic/fifo_top.sv
sim/tb_fifo_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the FIFO testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -f src.f --top-module tb_fifo_top \
  -Mdir "$BUILD_DIR" -o tb_fifo_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_fifo_top" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
